// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_channel_readout
FILELIST  = channel_readout.f
SIM       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: channel_readout.f
src/link_pkg.sv
src/ctl_pkg.sv
src/master_reset_timer.sv
src/readout_fsm.sv
src/burst_unpacker.sv
src/link_tx_mux.sv
src/done_delay.sv
src/channel_readout_top.sv
verification/tb_channel_readout.sv

// File: src/burst_unpacker.sv
module burst_unpacker (
  input  logic                    clk125,
  input  logic                    rst_n,
  input  logic                    full_reset,     // sync clear, drops a held burst
  input  link_pkg::burst_stream_t mem_rd,         // 128-bit bursts from memory
  output logic                    mem_rd_ready,
  output link_pkg::word_stream_t  mem_word,       // 32-bit words toward the link mux
  input  logic                    mem_word_ready
);

  link_pkg::burst_t burst_q; // held burst, payload only
  logic             last_q;  // held burst closes the fill
  logic             full_q;  // a burst is held
  logic [$clog2(link_pkg::WORDS_PER_BURST)-1:0] idx_q; // word being offered
  logic             at_end;  // offering the fourth word
  logic             take;    // word taken this cycle
  logic             accept;  // burst taken this cycle

  assign at_end = (idx_q == ($bits(idx_q))'(link_pkg::WORDS_PER_BURST - 1));
  assign take   = full_q && mem_word_ready;
  assign accept = mem_rd.valid && mem_rd_ready;

  // refill in the same cycle the fourth word leaves
  assign mem_rd_ready = !full_q || (take && at_end);

  // lowest word first
  assign mem_word.valid = full_q;
  assign mem_word.last  = last_q && at_end;
  assign mem_word.data  =
    burst_q[idx_q*$bits(link_pkg::word_t) +: $bits(link_pkg::word_t)];

  ////////////////////
  // control

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      idx_q  <= '0;
      last_q <= 1'b0;
    end else if (full_reset) begin
      full_q <= 1'b0;
      idx_q  <= '0;
      last_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
      idx_q  <= '0;          // new burst starts at its low word
      last_q <= mem_rd.last;
    end else if (take) begin
      idx_q <= idx_q + 1'b1; // wraps to 0 after the fourth word
      if (at_end) begin
        full_q <= 1'b0;
      end
    end
  end

  // burst payload
  always_ff @(posedge clk125) begin
    if (accept) begin
      burst_q <= mem_rd.data;
    end
  end

endmodule

// File: src/channel_readout_top.sv
module channel_readout_top (
  input  logic                    clk125,
  input  logic                    rst_n,

  // control from the master FPGA, all async
  input  logic                    rst_from_master,
  input  logic                    readout_pause,
  input  ctl_pkg::buf_flags_t     ext_done_buffer,
  input  logic                    ddr3_buffer,

  // fill readout request from the command side
  input  logic                    read_req,

  // command processor stream
  input  link_pkg::word_stream_t  cmd_tx,
  output logic                    cmd_tx_ready,

  // memory read bursts
  input  link_pkg::burst_stream_t mem_rd,
  output logic                    mem_rd_ready,

  // serial link
  output link_pkg::word_stream_t  link_tx,
  input  logic                    link_tx_ready,

  // status
  output logic                    read_done,
  output logic                    acq_done_latch,
  output logic                    evt_cnt_reset,
  output logic                    full_reset
);

  link_pkg::word_stream_t mem_word;       // unpacker to mux
  logic                   mem_word_ready;
  link_pkg::link_xfer_t   link_xfer;      // mux to readout FSM
  logic                   use_mem_data;   // readout FSM to mux

  ////////////////////
  // reset sorting

  master_reset_timer i_master_reset_timer (
    .clk125          (clk125),
    .rst_n           (rst_n),
    .rst_from_master (rst_from_master),
    .evt_cnt_reset   (evt_cnt_reset),
    .full_reset      (full_reset)
  );

  ////////////////////
  // readout path

  readout_fsm i_readout_fsm (
    .clk125       (clk125),
    .rst_n        (rst_n),
    .full_reset   (full_reset),
    .read_req     (read_req),
    .link_xfer    (link_xfer),
    .use_mem_data (use_mem_data),
    .read_done    (read_done)
  );

  burst_unpacker i_burst_unpacker (
    .clk125         (clk125),
    .rst_n          (rst_n),
    .full_reset     (full_reset),
    .mem_rd         (mem_rd),
    .mem_rd_ready   (mem_rd_ready),
    .mem_word       (mem_word),
    .mem_word_ready (mem_word_ready)
  );

  link_tx_mux i_link_tx_mux (
    .clk125         (clk125),
    .rst_n          (rst_n),
    .readout_pause  (readout_pause),
    .use_mem_data   (use_mem_data),
    .cmd_tx         (cmd_tx),
    .cmd_tx_ready   (cmd_tx_ready),
    .mem_word       (mem_word),
    .mem_word_ready (mem_word_ready),
    .link_tx        (link_tx),
    .link_tx_ready  (link_tx_ready),
    .link_xfer      (link_xfer)
  );

  ////////////////////
  // idle buffer done flag

  done_delay i_done_delay (
    .clk125          (clk125),
    .rst_n           (rst_n),
    .full_reset      (full_reset),
    .ext_done_buffer (ext_done_buffer),
    .ddr3_buffer     (ddr3_buffer),
    .acq_done_latch  (acq_done_latch)
  );

endmodule

// File: src/ctl_pkg.sv
package ctl_pkg;

  ////////////////////
  // timing constants

  localparam int SYNC_STAGES       = 2;  // flops per async input synchronizer
  localparam int LONG_RESET_CYCLES = 16; // master reset held this long means full reset
  localparam int DONE_DELAY_STAGES = 5;  // extra stages after the done-flag synchronizer

  ////////////////////
  // control vectors

  typedef logic [4:0] rst_cnt_t;    // holds 0 .. LONG_RESET_CYCLES
  typedef logic [1:0] buf_flags_t;  // one done flag per memory buffer half

  // readout FSM, owner of the link
  typedef enum logic [1:0] {
    IDLE,         // command data on the link
    WAIT_CMD_END, // fill requested, command packet still open
    STREAM_MEM,   // memory data on the link
    DONE          // one-cycle end of fill
  } readout_state_t;

endpackage

// File: src/done_delay.sv
module done_delay (
  input  logic                clk125,
  input  logic                rst_n,
  input  logic                full_reset,      // sync clear of the delay line
  input  ctl_pkg::buf_flags_t ext_done_buffer, // async, last self-trigger written, per half
  input  logic                ddr3_buffer,     // async, half currently being written
  output logic                acq_done_latch   // idle half is safe to read
);

  ctl_pkg::buf_flags_t [ctl_pkg::SYNC_STAGES-1:0]       flag_sync_q; // flag synchronizer
  logic                [ctl_pkg::SYNC_STAGES-1:0]       buf_sync_q;  // buffer select sync
  ctl_pkg::buf_flags_t [ctl_pkg::DONE_DELAY_STAGES-1:0] dly_q;       // read FIFO catch-up
  logic                                                 buf_s;

  assign buf_s = buf_sync_q[ctl_pkg::SYNC_STAGES-1];

  ////////////////////
  // synchronizers

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      flag_sync_q <= '0;
      buf_sync_q  <= '0;
    end else begin
      flag_sync_q <= {flag_sync_q[ctl_pkg::SYNC_STAGES-2:0], ext_done_buffer};
      buf_sync_q  <= {buf_sync_q[ctl_pkg::SYNC_STAGES-2:0], ddr3_buffer};
    end
  end

  // the read side of the memory FIFO lags the write side, hold the flags back
  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      dly_q <= '0;
    end else if (full_reset) begin
      dly_q <= '0;
    end else begin
      dly_q <= {dly_q[ctl_pkg::DONE_DELAY_STAGES-2:0], flag_sync_q[ctl_pkg::SYNC_STAGES-1]};
    end
  end

  // flag of the half not being written
  assign acq_done_latch = dly_q[ctl_pkg::DONE_DELAY_STAGES-1][~buf_s];

endmodule

// File: src/link_pkg.sv
package link_pkg;

  ////////////////////
  // sizes

  localparam int WORDS_PER_BURST = 4; // 32-bit link words per memory burst

  ////////////////////
  // payload vectors

  typedef logic [31:0] word_t;                                // one serial link word
  typedef logic [WORDS_PER_BURST*$bits(word_t)-1:0] burst_t;  // one memory read burst

  ////////////////////
  // streams, ready travels separately in the opposite direction

  // 34 bits: valid, last, data
  typedef struct packed {
    logic  valid;
    logic  last;   // final word of a packet
    word_t data;
  } word_stream_t;

  // 130 bits: valid, last, data
  typedef struct packed {
    logic   valid;
    logic   last;  // final burst of a fill
    burst_t data;
  } burst_stream_t;

  // one word taken by the link
  typedef struct packed {
    logic fire;    // valid and ready both high this cycle
    logic last;    // that word closed a packet
  } link_xfer_t;

endpackage

// File: src/link_tx_mux.sv
module link_tx_mux (
  input  logic                   clk125,
  input  logic                   rst_n,
  input  logic                   readout_pause,  // async level from the master
  input  logic                   use_mem_data,   // select memory words over commands
  input  link_pkg::word_stream_t cmd_tx,         // command processor stream
  output logic                   cmd_tx_ready,
  input  link_pkg::word_stream_t mem_word,       // unpacked memory stream
  output logic                   mem_word_ready,
  output link_pkg::word_stream_t link_tx,        // toward the serial link
  input  logic                   link_tx_ready,
  output link_pkg::link_xfer_t   link_xfer       // word taken by the link
);

  logic [ctl_pkg::SYNC_STAGES-1:0] pause_q;  // pause synchronizer
  logic                            pause_s;  // synchronized pause
  link_pkg::word_stream_t          src;      // selected source
  logic                            ready_g;  // link ready, gated by pause

  ////////////////////
  // pause sync, comes out of reset paused so nothing moves until it settles

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      pause_q <= '1;
    end else begin
      pause_q <= {pause_q[ctl_pkg::SYNC_STAGES-2:0], readout_pause};
    end
  end

  assign pause_s = pause_q[ctl_pkg::SYNC_STAGES-1];

  ////////////////////
  // 2:1 select, no added latency

  assign src = use_mem_data ? mem_word : cmd_tx;

  assign link_tx.valid = src.valid && !pause_s;
  assign link_tx.last  = src.last;
  assign link_tx.data  = {<<{src.data}}; // link wants the bit order swapped

  // ready only to the active source
  assign ready_g        = link_tx_ready && !pause_s;
  assign mem_word_ready = use_mem_data && ready_g;
  assign cmd_tx_ready   = !use_mem_data && ready_g;

  // transfer report for the readout FSM
  assign link_xfer.fire = link_tx.valid && link_tx_ready;
  assign link_xfer.last = link_tx.last;

endmodule

// File: src/master_reset_timer.sv
module master_reset_timer (
  input  logic clk125,
  input  logic rst_n,
  input  logic rst_from_master, // async level from the master FPGA
  output logic evt_cnt_reset,   // short pulse seen
  output logic full_reset       // long pulse seen
);

  logic [ctl_pkg::SYNC_STAGES-1:0] sync_q; // master reset synchronizer
  logic                            pulse_s; // synchronized master reset
  ctl_pkg::rst_cnt_t               cnt_q;   // synchronized cycles high, saturating
  logic                            at_long; // count has hit the full-reset threshold

  assign pulse_s = sync_q[ctl_pkg::SYNC_STAGES-1];
  assign at_long = (cnt_q == ctl_pkg::rst_cnt_t'(ctl_pkg::LONG_RESET_CYCLES));

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      sync_q        <= '0;
      cnt_q         <= '0;
      evt_cnt_reset <= 1'b0;
      full_reset    <= 1'b0;
    end else begin
      sync_q        <= {sync_q[ctl_pkg::SYNC_STAGES-2:0], rst_from_master};
      evt_cnt_reset <= 1'b0; // both outputs are single-cycle strobes
      full_reset    <= 1'b0;
      if (pulse_s) begin
        // measure the pulse, stop at threshold so the long reset fires once
        if (!at_long) begin
          cnt_q      <= cnt_q + ctl_pkg::rst_cnt_t'(1);
          full_reset <= (cnt_q == ctl_pkg::rst_cnt_t'(ctl_pkg::LONG_RESET_CYCLES - 1));
        end
      end else begin
        // falling edge of a short pulse
        evt_cnt_reset <= (cnt_q != '0) && !at_long;
        cnt_q         <= '0;
      end
    end
  end

endmodule

// File: src/readout_fsm.sv
module readout_fsm (
  input  logic                 clk125,
  input  logic                 rst_n,
  input  logic                 full_reset,   // sync clear from the master reset timer
  input  logic                 read_req,     // start a fill readout, one cycle
  input  link_pkg::link_xfer_t link_xfer,    // words taken by the link
  output logic                 use_mem_data, // memory data owns the link
  output logic                 read_done     // fill readout finished, one cycle
);

  ctl_pkg::readout_state_t state_q;
  ctl_pkg::readout_state_t state_d;
  logic                    cmd_open_q;   // command packet started, last not yet taken
  logic                    cmd_fire;     // command word taken this cycle
  logic                    cmd_open_now; // packet status including this cycle's transfer

  // command data is on the link in every state but STREAM_MEM
  assign cmd_fire     = link_xfer.fire && (state_q != ctl_pkg::STREAM_MEM);
  assign cmd_open_now = cmd_fire ? !link_xfer.last : cmd_open_q;

  ////////////////////
  // next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctl_pkg::IDLE: begin
        if (read_req) begin
          // switch only at a packet boundary
          state_d = cmd_open_now ? ctl_pkg::WAIT_CMD_END : ctl_pkg::STREAM_MEM;
        end
      end
      ctl_pkg::WAIT_CMD_END: begin
        if (cmd_fire && link_xfer.last) begin
          state_d = ctl_pkg::STREAM_MEM;
        end
      end
      ctl_pkg::STREAM_MEM: begin
        if (link_xfer.fire && link_xfer.last) begin // last word of the fill
          state_d = ctl_pkg::DONE;
        end
      end
      ctl_pkg::DONE: state_d = ctl_pkg::IDLE;
      default: state_d = ctl_pkg::IDLE;
    endcase
  end

  ////////////////////
  // state and packet tracking

  always_ff @(posedge clk125 or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ctl_pkg::IDLE;
      cmd_open_q <= 1'b0;
    end else if (full_reset) begin
      state_q    <= ctl_pkg::IDLE;
      cmd_open_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      cmd_open_q <= cmd_open_now;
    end
  end

  assign use_mem_data = (state_q == ctl_pkg::STREAM_MEM);
  assign read_done    = (state_q == ctl_pkg::DONE);   // link back to commands here

endmodule

// File: verification/tb_channel_readout.sv
module tb_channel_readout;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 4000; // about four times the length of all phases together

  logic                    clk125;
  logic                    rst_n;
  logic                    rst_from_master;
  logic                    readout_pause;
  logic                    read_req;
  ctl_pkg::buf_flags_t     ext_done_buffer;
  logic                    ddr3_buffer;
  link_pkg::word_stream_t  cmd_tx;
  logic                    cmd_tx_ready;
  link_pkg::burst_stream_t mem_rd;
  logic                    mem_rd_ready;
  link_pkg::word_stream_t  link_tx;
  logic                    link_tx_ready;
  logic                    read_done;
  logic                    acq_done_latch;
  logic                    evt_cnt_reset;
  logic                    full_reset;

  ////////////////////
  // model state

  logic [31:0]         lfsr;          // Galois LFSR stepped once per random bit
  logic [32:0]         exp_cmd[$];    // command words in order as {last, bit-reversed data}
  logic [32:0]         exp_mem[$];    // same for memory words with the lowest of a burst first
  logic                mem_own;       // memory data owns the link this cycle
  logic                cmd_open;      // command packet started on the link with last not yet seen
  logic                req_wait;      // fill requested, waiting for the packet end
  logic                done_exp;      // read_done due this cycle
  logic                cmd_took;      // command word accepted this cycle
  logic                mem_took;      // burst accepted this cycle
  logic                cmd_en;        // keep starting command packets
  logic                ddr3_last;
  int                  cmd_pkt_left;  // words left in the packet being generated
  int                  bursts_req;    // bursts asked for so far by the main sequence
  int                  bursts_sent;   // bursts generated so far by the driver
  int                  cycles;
  int                  pause_cnt;     // consecutive cycles with pause high
  int                  dd_cnt;        // cycles since ddr3_buffer moved or a full reset
  int                  done_cnt;
  int                  evt_cnt;
  int                  full_cnt;
  ctl_pkg::buf_flags_t hist [8];      // ext_done_buffer history with newest first

  channel_readout_top i_dut (.*); // port names match the signals above

  initial begin
    clk125 = 1'b0;
    forever #20 clk125 = ~clk125;
  end

  ////////////////////
  // helpers

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // x^32+x^22+x^2+x+1
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // link sends bit 31 where the source had bit 0
  function automatic link_pkg::word_t flip_bits(input link_pkg::word_t w);
    link_pkg::word_t r;
    int              i;
    for (i = 0; i < 32; i++) begin
      r[i] = w[31-i];
    end
    return r;
  endfunction

  function automatic string value_error(input string name, input logic [31:0] e,
                                        input logic [31:0] g);
    return $sformatf("ERROR t=%0t %s exp %h got %h", $time, name, e, g);
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk125);
    #2; // inputs move just after the edge
  endtask

  task automatic check_low(input string name, input logic v);
    assert (v === 1'b0) else fail_now(value_error(name, 0, 32'(v)));
  endtask

  // one fill readout that may be paused part way through
  task automatic run_fill(input int bursts, input bit with_pause);
    int done_start;
    done_start = done_cnt;
    bursts_req = bursts_req + bursts;
    read_req   = 1'b1;
    wait_cycles(1);
    read_req   = 1'b0;
    if (with_pause) begin
      wait_cycles(3);
      readout_pause = 1'b1;
      wait_cycles(6); // well past the synchronizer
      readout_pause = 1'b0;
    end
    while (done_cnt == done_start) wait_cycles(1);
    wait_cycles(1); // FSM back in IDLE
  endtask

  ////////////////////
  // stimulus with controls latched at the edge and inputs driven 2 ns later

  always @(posedge clk125) begin : drive_inputs
    int   k;
    logic want_cmd;
    int   burst_goal;
    if (rst_n) begin
      want_cmd   = cmd_en || (cmd_pkt_left != 0); // finish an open packet
      burst_goal = bursts_req;
      #2;
      ext_done_buffer = ctl_pkg::buf_flags_t'(rand_bits(2));
      link_tx_ready   = |rand_bits(2); // ready about three cycles in four
      if (cmd_took) cmd_tx.valid = 1'b0;
      if (!cmd_tx.valid && want_cmd && rand_bits(1) != 0) begin
        if (cmd_pkt_left == 0) cmd_pkt_left = int'(rand_bits(2)) + 1; // 1..4 words
        cmd_tx.data  = rand_bits(32);
        cmd_tx.last  = (cmd_pkt_left == 1);
        cmd_tx.valid = 1'b1;
        cmd_pkt_left--;
        exp_cmd.push_back({cmd_tx.last, flip_bits(cmd_tx.data)});
      end
      if (mem_took) mem_rd.valid = 1'b0;
      if (!mem_rd.valid && bursts_sent < burst_goal && rand_bits(1) != 0) begin
        for (k = 0; k < 4; k++) mem_rd.data[k*32 +: 32] = rand_bits(32);
        mem_rd.last  = (bursts_sent + 1 == burst_goal); // last burst of this fill
        mem_rd.valid = 1'b1;
        bursts_sent++;
        for (k = 0; k < 4; k++) begin
          exp_mem.push_back({mem_rd.last && (k == 3), flip_bits(mem_rd.data[k*32 +: 32])});
        end
      end
    end
  end

  ////////////////////
  // checks and model sampled at the falling edge where everything has settled

  always @(negedge clk125) begin : check_outputs
    logic [32:0] want;
    logic        fire;
    int          i;
    if (rst_n) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
        fail_now("timeout, the run did not finish within the cycle limit");
      end
      fire     = link_tx.valid && link_tx_ready;
      cmd_took = cmd_tx.valid && cmd_tx_ready;
      mem_took = mem_rd.valid && mem_rd_ready;
      assert (read_done == done_exp)
        else fail_now(value_error("read_done", 32'(done_exp), 32'(read_done)));
      pause_cnt = readout_pause ? pause_cnt + 1 : 0;
      if (pause_cnt >= 3) begin // synchronized pause is high by now
        assert (!link_tx.valid)
          else fail_now(value_error("link_tx.valid", 0, 32'(link_tx.valid)));
      end
      if (fire) begin
        assert (mem_own ? exp_mem.size() != 0 : exp_cmd.size() != 0)
          else fail_now("a word came out on the link while none was expected");
        if (mem_own) want = exp_mem.pop_front();
        else want = exp_cmd.pop_front();
        assert (link_tx.data == want[31:0])
          else fail_now(value_error("link_tx.data", want[31:0], link_tx.data));
        assert (link_tx.last == want[32])
          else fail_now(value_error("link_tx.last", 32'(want[32]), 32'(link_tx.last)));
      end
      // link ownership for the next cycle
      done_exp = 1'b0;
      if (mem_own) begin
        if (fire && want[32]) begin
          mem_own  = 1'b0;
          done_exp = 1'b1;
        end
      end else begin
        if (fire) cmd_open = !want[32];
        if (read_req) req_wait = 1'b1;
        if (req_wait && !cmd_open) begin // switch only between packets
          mem_own  = 1'b1;
          req_wait = 1'b0;
        end
      end
      if (read_done) done_cnt++;
      if (evt_cnt_reset) evt_cnt++;
      if (full_reset) full_cnt++;
      // done flag of the idle half from seven cycles back
      for (i = 7; i > 0; i--) hist[i] = hist[i-1];
      hist[0]   = ext_done_buffer;
      dd_cnt    = (ddr3_buffer != ddr3_last || full_reset) ? 0 : dd_cnt + 1;
      ddr3_last = ddr3_buffer;
      if (dd_cnt >= 8) begin
        assert (acq_done_latch == hist[7][!ddr3_buffer])
          else fail_now(value_error("acq_done_latch", 32'(hist[7][!ddr3_buffer]),
                                    32'(acq_done_latch)));
      end
    end
  end

  ////////////////////
  // sequence

  initial begin
    lfsr = 32'd2; // seed
    rst_n = 1'b0;
    rst_from_master = 1'b0;
    readout_pause = 1'b0;
    read_req = 1'b0;
    ext_done_buffer = '0;
    ddr3_buffer = 1'b0;
    cmd_tx = '0;
    mem_rd = '0;
    link_tx_ready = 1'b0;
    mem_own = 1'b0;
    cmd_open = 1'b0;
    req_wait = 1'b0;
    done_exp = 1'b0;
    cmd_took = 1'b0;
    mem_took = 1'b0;
    cmd_en = 1'b0;
    ddr3_last = 1'b0;
    cmd_pkt_left = 0;
    bursts_req = 0;
    bursts_sent = 0;
    cycles = 0;
    pause_cnt = 0;
    dd_cnt = 0;
    done_cnt = 0;
    evt_cnt = 0;
    full_cnt = 0;
    foreach (hist[i]) hist[i] = '0;
    @(negedge clk125); // outputs in reset
    check_low("link_tx.valid", link_tx.valid);
    check_low("cmd_tx_ready", cmd_tx_ready);
    check_low("read_done", read_done);
    check_low("evt_cnt_reset", evt_cnt_reset);
    check_low("full_reset", full_reset);
    check_low("acq_done_latch", acq_done_latch);
    repeat (4) @(posedge clk125);
    #2 rst_n = 1'b1;
    cmd_en = 1'b1; // commands only
    wait_cycles(200);
    cmd_en = 1'b0; // fill at a packet boundary
    while (exp_cmd.size() != 0 || cmd_open) wait_cycles(1);
    run_fill(6, 1'b0);
    cmd_en = 1'b1; // commands resume
    wait_cycles(100);
    ddr3_buffer = 1'b1; // fills requested inside open packets with the first one paused
    for (int n = 0; n < 4; n++) begin
      while (!cmd_open) wait_cycles(1);
      run_fill(5, n == 0);
    end
    cmd_en = 1'b0;
    while (exp_cmd.size() != 0 || exp_mem.size() != 0 || cmd_open) wait_cycles(1);
    wait_cycles(4);
    rst_from_master = 1'b1; // short master reset
    wait_cycles(5);
    rst_from_master = 1'b0;
    wait_cycles(10);
    assert (evt_cnt == 1) else fail_now(value_error("evt_cnt_reset pulses", 1, evt_cnt));
    assert (full_cnt == 0) else fail_now(value_error("full_reset pulses", 0, full_cnt));
    rst_from_master = 1'b1; // long master reset
    wait_cycles(30);
    rst_from_master = 1'b0;
    wait_cycles(10);
    assert (evt_cnt == 1) else fail_now(value_error("evt_cnt_reset pulses", 1, evt_cnt));
    assert (full_cnt == 1) else fail_now(value_error("full_reset pulses", 1, full_cnt));
    $display("Verification passed");
    $finish;
  end

endmodule
